// ==== mipsPipe.f ====
+incdir+rtl
rtl/mipsIsaPkg.sv
rtl/mipsPipePkg.sv
rtl/syncRam.sv
rtl/pipeReg.sv
rtl/controlUnit.sv
rtl/hazardUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/mipsPipe.sv
bench/mipsPipe_sva.sv
bench/mipsPipeTb.sv

// ==== Bender.yml ====
package:
  name: mipsPipe

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mipsIsaPkg.sv
      - rtl/mipsPipePkg.sv
      - rtl/syncRam.sv
      - rtl/pipeReg.sv
      - rtl/controlUnit.sv
      - rtl/hazardUnit.sv
      - rtl/decodeStage.sv
      - rtl/executeStage.sv
      - rtl/mipsPipe.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/mipsPipe_sva.sv
      - bench/mipsPipeTb.sv

// ==== bench/mipsPipeTb.sv ====
////////////////////////////////////////////////////////////
// MIPS core testbench
// Random program, in-order ISA model, write-port checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsPipeTb;
  import mipsIsaPkg::*;
  import mipsPipePkg::*;

  localparam int N_RAND      = 64;
  localparam int N_PROG      = N_RAND + 8;
  localparam int RESET_CYC   = 4;
  localparam int DRAIN_CYC   = 8;
  localparam int TIMEOUT_CYC = N_RAND + 2 * N_PROG + 40;
  localparam int KIND_ALU    = 0;
  localparam int KIND_FWD    = 1;
  localparam int KIND_LOAD   = 2;

  logic                    clk;
  logic                    ci_rst;
  logic                    instLoad;
  logic [`MIPS_MEM_AW-1:0] instAddr;
  instr_t                  instData;
  regWrite_t               regWr;
  memWrite_t               memWr;

  integer    seed;
  word_t     prog [N_PROG];
  regWrite_t regExp [$];
  int        regKind [$];
  memWrite_t memExp [$];
  int        cycleCount;
  logic      loadPhase;
  int        errReset, errAlu, errFwd, errStore, errLoad;
  int        nAlu, nFwd, nStore, nLoad, nLoadUse;

  mipsPipe UUT (
    .clk      (clk),
    .ci_rst   (ci_rst),
    .instLoad (instLoad),
    .instAddr (instAddr),
    .instData (instData),
    .regWr    (regWr),
    .memWr    (memWr)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Watchdog, counts every cycle from time zero
  initial begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYC) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, expected writes still pending", cycleCount);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Program generation
  ////////////////////////////////////////////////////////////
  function automatic int randBelow(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [5:0] pickFunct(input int k);
    case (k)
      0:       return FN_ADD;
      1:       return FN_SUB;
      2:       return FN_AND;
      3:       return FN_OR;
      default: return FN_SLT;
    endcase
  endfunction

  function automatic word_t encodeR(input regIdx_t rs, input regIdx_t rt,
                                    input regIdx_t rd, input logic [5:0] fn);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t encodeI(input logic [5:0] op, input regIdx_t rs,
                                    input regIdx_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic buildProgram();
    logic [`MIPS_MEM_AW-1:0] stored [$];
    logic [`MIPS_MEM_AW-1:0] wa;
    regIdx_t                 rs, rt, rd;
    logic [5:0]              fn;
    int                      kind;
    int                      i;
    i = 0;
    while (i < N_RAND) begin
      kind = randBelow(10);
      rs   = regIdx_t'(randBelow(8));
      rt   = regIdx_t'(randBelow(8));
      rd   = regIdx_t'(randBelow(8));
      fn   = pickFunct(randBelow(5));
      // No load before the first store
      if (kind >= 8 && stored.size() == 0) begin
        kind = 6;
      end
      if (kind < 4) begin
        prog[i] = encodeR(rs, rt, rd, fn);
      end else if (kind < 6) begin
        prog[i] = encodeI(OP_ADDI, rs, rt, 16'(randBelow(65536)));
      end else if (kind < 8) begin
        wa = `MIPS_MEM_AW'(randBelow(256));
        stored.push_back(wa);
        prog[i] = encodeI(OP_SW, 5'd0, rt, {6'd0, wa, 2'b00});
      end else begin
        wa = stored[randBelow(stored.size())];
        prog[i] = encodeI(OP_LW, 5'd0, rt, {6'd0, wa, 2'b00});
        // Direct user of the load target
        if (i + 1 < N_RAND) begin
          i++;
          prog[i] = encodeR(rt, rs, rd, fn);
        end
      end
      i++;
    end
    // Trailing NOPs
    for (int k = N_RAND; k < N_PROG; k++) begin
      prog[k] = '0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // In-order ISA model
  ////////////////////////////////////////////////////////////
  task automatic runModel();
    word_t                   regs [8];
    word_t                   dmem [2 ** `MIPS_MEM_AW];
    regIdx_t                 prevDest [2];
    regIdx_t                 loadDest;
    logic                    prevLoad;
    word_t                   w, a, b, res;
    logic [5:0]              op, fn;
    regIdx_t                 rs, rt, dest;
    logic                    writes, dep;
    int                      kind;
    regWrite_t               rw;
    memWrite_t               mw;
    for (int r = 0; r < 8; r++) begin
      regs[r] = '0;
    end
    prevDest[0] = '0;
    prevDest[1] = '0;
    prevLoad    = 1'b0;
    loadDest    = '0;
    for (int i = 0; i < N_PROG; i++) begin
      w      = prog[i];
      op     = w[31:26];
      rs     = w[25:21];
      rt     = w[20:16];
      fn     = w[5:0];
      a      = regs[rs[2:0]];
      b      = regs[rt[2:0]];
      writes = 1'b0;
      dest   = '0;
      res    = '0;
      kind   = KIND_ALU;
      dep    = (rs != 0) && (rs == prevDest[0] || rs == prevDest[1]);
      if (prevLoad && (rs == loadDest || rt == loadDest)) begin
        nLoadUse++;
      end
      if (op == OP_RTYPE) begin
        dep    = dep || ((rt != 0) && (rt == prevDest[0] || rt == prevDest[1]));
        writes = 1'b1;
        dest   = w[15:11];
        case (fn)
          FN_ADD:  res = a + b;
          FN_SUB:  res = a - b;
          FN_AND:  res = a & b;
          FN_OR:   res = a | b;
          FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: writes = 1'b0;
        endcase
      end else if (op == OP_ADDI) begin
        res    = a + {{16{w[15]}}, w[15:0]};
        writes = 1'b1;
        dest   = rt;
      end else if (op == OP_LW) begin
        res    = dmem[w[`MIPS_MEM_AW+1:2]];
        writes = 1'b1;
        dest   = rt;
        kind   = KIND_LOAD;
      end else if (op == OP_SW) begin
        dmem[w[`MIPS_MEM_AW+1:2]] = b;
        mw.valid = 1'b1;
        mw.addr  = w[`MIPS_MEM_AW+1:2];
        mw.data  = b;
        memExp.push_back(mw);
      end
      if (kind == KIND_ALU && dep) begin
        kind = KIND_FWD;
      end
      prevLoad    = (op == OP_LW);
      loadDest    = rt;
      prevDest[1] = prevDest[0];
      prevDest[0] = writes ? dest : '0;
      // r0 writes never show on the port
      if (writes && dest != 0) begin
        regs[dest[2:0]] = res;
        rw.valid = 1'b1;
        rw.addr  = dest;
        rw.data  = res;
        regExp.push_back(rw);
        regKind.push_back(kind);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic checkRegWrite(input regWrite_t got);
    regWrite_t exp;
    int        kind;
    int        bad;
    if (regExp.size() == 0) begin
      $display("Extra register write to r%0d, model has no write left", got.addr);
      errFwd++;
    end else begin
      exp  = regExp.pop_front();
      kind = regKind.pop_front();
      bad  = 0;
      if (got.addr !== exp.addr) begin
        $display("ERR regWr.addr got 0x%h exp 0x%h", got.addr, exp.addr);
        bad++;
      end
      if (got.data !== exp.data) begin
        $display("ERR regWr.data got 0x%h exp 0x%h", got.data, exp.data);
        bad++;
      end
      case (kind)
        KIND_LOAD: begin
          nLoad++;
          errLoad += bad;
        end
        KIND_FWD: begin
          nFwd++;
          errFwd += bad;
        end
        default: begin
          nAlu++;
          errAlu += bad;
        end
      endcase
    end
  endtask

  task automatic checkMemWrite(input memWrite_t got);
    memWrite_t exp;
    if (memExp.size() == 0) begin
      $display("Extra store to word 0x%h, model has no store left", got.addr);
      errStore++;
    end else begin
      exp = memExp.pop_front();
      nStore++;
      if (got.addr !== exp.addr) begin
        $display("ERR memWr.addr got 0x%h exp 0x%h", got.addr, exp.addr);
        errStore++;
      end
      if (got.data !== exp.data) begin
        $display("ERR memWr.data got 0x%h exp 0x%h", got.data, exp.data);
        errStore++;
      end
    end
  endtask

  // Outputs are registered, stable at the falling edge
  task automatic nextCycle();
    @(negedge clk);
    if (loadPhase) begin
      if (regWr.valid !== 1'b0 || memWr.valid !== 1'b0) begin
        $display("Write port active during reset or program load");
        errReset++;
      end
    end else begin
      if (regWr.valid === 1'b1) begin
        checkRegWrite(regWr);
      end else if (regWr.valid !== 1'b0) begin
        $display("regWr.valid is unknown during execution");
        errAlu++;
      end
      if (memWr.valid === 1'b1) begin
        checkMemWrite(memWr);
      end else if (memWr.valid !== 1'b0) begin
        $display("memWr.valid is unknown during execution");
        errStore++;
      end
    end
  endtask

  function automatic string verdict(input int errs);
    return (errs == 0) ? "ok" : "FAILED";
  endfunction

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    ci_rst    = 1'b1;
    instLoad  = 1'b0;
    instAddr  = '0;
    instData  = '0;
    seed      = 32'heabc_a1c3;
    loadPhase = 1'b1;
    errReset  = 0;
    errAlu    = 0;
    errFwd    = 0;
    errStore  = 0;
    errLoad   = 0;
    nAlu      = 0;
    nFwd      = 0;
    nStore    = 0;
    nLoad     = 0;
    nLoadUse  = 0;
    buildProgram();
    runModel();
    repeat (RESET_CYC) nextCycle();
    // Load starts as reset drops so no unloaded word is fetched
    ci_rst   = 1'b0;
    instLoad = 1'b1;
    for (int k = 0; k < N_PROG; k++) begin
      instAddr = k[`MIPS_MEM_AW-1:0];
      instData = instr_t'(prog[k]);
      nextCycle();
    end
    instLoad  = 1'b0;
    instAddr  = '0;
    instData  = '0;
    loadPhase = 1'b0;
    $display("[1] reset and load quiet: %s, %0d errors", verdict(errReset), errReset);
    // Run until the model's writes are all seen
    while (regExp.size() != 0 || memExp.size() != 0) begin
      nextCycle();
    end
    repeat (DRAIN_CYC) nextCycle();
    $display("[2] ALU and addi: %s, %0d writes, %0d errors", verdict(errAlu), nAlu, errAlu);
    $display("[3] forwarding: %s, %0d dependent writes, %0d errors",
             verdict(errFwd), nFwd, errFwd);
    $display("[4] stores: %s, %0d stores, %0d errors", verdict(errStore), nStore, errStore);
    $display("[5] loads: %s, %0d loads, %0d load-use pairs, %0d errors",
             verdict(errLoad), nLoad, nLoadUse, errLoad);
    $display("Totals: %0d register writes, %0d stores, %0d errors in %0d cycles",
             nAlu + nFwd + nLoad, nStore,
             errReset + errAlu + errFwd + errStore + errLoad, cycleCount);
    if (errReset + errAlu + errFwd + errStore + errLoad == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/mipsPipe_sva.sv ====
////////////////////////////////////////////////////////////
// MIPS core assertions
// Observation ports and load-use stall
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mipsPipe_sva (
  input logic                   clk,
  input logic                   ci_rst,
  input logic                   instLoad,
  input logic                   stall,
  input mipsPipePkg::regWrite_t regWr,
  input mipsPipePkg::memWrite_t memWr
);

  // r0 writes are never reported, reported data is known
  noR0Write: assert property (@(posedge clk) disable iff (ci_rst)
    regWr.valid |-> ((regWr.addr != '0) && !$isunknown(regWr.data)))
    else $error("regWr valid with destination r0 or unknown data");

  // One bubble per load-use
  singleStall: assert property (@(posedge clk) disable iff (ci_rst)
    stall |=> !stall)
    else $error("stall held for two cycles");

  // Core quiet while the program is loaded
  quietOnLoad: assert property (@(posedge clk) disable iff (ci_rst)
    instLoad |-> (!regWr.valid && !memWr.valid))
    else $error("write port active during program load");

endmodule

bind mipsPipe mipsPipe_sva svaCheck (
  .clk      (clk),
  .ci_rst   (ci_rst),
  .instLoad (instLoad),
  .stall    (stall),
  .regWr    (regWr),
  .memWr    (memWr)
);

// ==== rtl/mipsPipe.sv ====
////////////////////////////////////////////////////////////
// Five-stage pipelined MIPS core
// PC, stage registers, memories and observation ports
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mips_defines.svh"

module mipsPipe (
  input  logic                    clk,
  input  logic                    ci_rst,
  input  logic                    instLoad,
  input  logic [`MIPS_MEM_AW-1:0] instAddr,
  input  mipsIsaPkg::instr_t      instData,
  output mipsPipePkg::regWrite_t  regWr,
  output mipsPipePkg::memWrite_t  memWr
);
  import mipsIsaPkg::*;
  import mipsPipePkg::*;

  // Byte address of the next fetch
  word_t                   pc;
  word_t                   pcPlus4;
  logic [`MIPS_MEM_AW-1:0] imemAddr;
  instr_t                  imemData;
  word_t                   dmemData;
  logic                    stall;
  fwdSel_t                 forwardA;
  fwdSel_t                 forwardB;
  ctrl_t                   ctrl;
  ifId_t                   ifIdD;
  ifId_t                   ifIdQ;
  idEx_t                   idExD;
  idEx_t                   idExQ;
  exMem_t                  exMemD;
  exMem_t                  exMemQ;
  memWb_t                  memWbD;
  memWb_t                  memWbQ;

  ////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////
  assign pcPlus4 = pc + 32'd4;

  // Load parks the PC at 0 so execution restarts there
  always_ff @(posedge clk or posedge ci_rst) begin
    if (ci_rst) begin
      pc <= '0;
    end else if (instLoad) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pcPlus4;
    end
  end

  assign imemAddr = instLoad ? instAddr : pc[`MIPS_MEM_AW+1:2];

  // Read frozen on stall so Fetch keeps its word
  syncRam #(.payload_t(instr_t)) instRam (
    .clk   (clk),
    .en    (instLoad || !stall),
    .we    (instLoad),
    .addr  (imemAddr),
    .wdata (instData),
    .rdata (imemData)
  );

  // After the last increment pc is PC+4 of the word now in Fetch
  assign ifIdD.instr   = imemData;
  assign ifIdD.pcPlus4 = pc;

  // pc of zero means RAM output is not a fetched word yet
  pipeReg #(.payload_t(ifId_t)) ifIdReg (
    .clk    (clk),
    .ci_rst (ci_rst),
    .en     (!stall),
    .clr    (instLoad || (pc == '0)),
    .d      (ifIdD),
    .q      (ifIdQ)
  );

  ////////////////////////////////////////////////////////////
  // Decode and Execute
  ////////////////////////////////////////////////////////////
  controlUnit ctrlUnit (
    .instr (ifIdQ.instr),
    .ctrl  (ctrl)
  );

  decodeStage idStage (
    .clk    (clk),
    .ci_rst (ci_rst),
    .instr  (ifIdQ.instr),
    .ctrl   (ctrl),
    .wb     (memWbQ),
    .idEx   (idExD)
  );

  hazardUnit hazUnit (
    .idRs        (ifIdQ.instr.rs),
    .idRt        (ifIdQ.instr.rt),
    .exRs        (idExQ.rs),
    .exRt        (idExQ.rt),
    .memWriteReg (exMemQ.writeReg),
    .wbWriteReg  (memWbQ.writeReg),
    .exMemToReg  (idExQ.ctrl.memToReg),
    .memRegWrite (exMemQ.regWrite),
    .wbRegWrite  (memWbQ.regWrite),
    .forwardA    (forwardA),
    .forwardB    (forwardB),
    .stall       (stall)
  );

  // Bubble into Execute on load-use
  pipeReg #(.payload_t(idEx_t)) idExReg (
    .clk    (clk),
    .ci_rst (ci_rst),
    .en     (1'b1),
    .clr    (stall),
    .d      (idExD),
    .q      (idExQ)
  );

  executeStage exStage (
    .idEx      (idExQ),
    .memAluOut (exMemQ.aluOut),
    .wbResult  (memWbQ.result),
    .forwardA  (forwardA),
    .forwardB  (forwardB),
    .exMem     (exMemD)
  );

  pipeReg #(.payload_t(exMem_t)) exMemReg (
    .clk    (clk),
    .ci_rst (ci_rst),
    .en     (1'b1),
    .clr    (1'b0),
    .d      (exMemD),
    .q      (exMemQ)
  );

  ////////////////////////////////////////////////////////////
  // Memory and Writeback
  ////////////////////////////////////////////////////////////
  // Addressed from the Execute ALU so load data lands in Memory
  syncRam #(.payload_t(word_t)) dataRam (
    .clk   (clk),
    .en    (1'b1),
    .we    (exMemD.memWrite),
    .addr  (exMemD.aluOut[`MIPS_MEM_AW+1:2]),
    .wdata (exMemD.writeData),
    .rdata (dmemData)
  );

  assign memWbD.regWrite = exMemQ.regWrite;
  assign memWbD.result   = exMemQ.memToReg ? dmemData : exMemQ.aluOut;
  assign memWbD.writeReg = exMemQ.writeReg;

  pipeReg #(.payload_t(memWb_t)) memWbReg (
    .clk    (clk),
    .ci_rst (ci_rst),
    .en     (1'b1),
    .clr    (1'b0),
    .d      (memWbD),
    .q      (memWbQ)
  );

  // Observation ports
  assign regWr.valid = memWbQ.regWrite && (memWbQ.writeReg != '0);
  assign regWr.addr  = memWbQ.writeReg;
  assign regWr.data  = memWbQ.result;

  // Store seen in its Memory cycle
  assign memWr.valid = exMemQ.memWrite;
  assign memWr.addr  = exMemQ.aluOut[`MIPS_MEM_AW+1:2];
  assign memWr.data  = exMemQ.writeData;

endmodule

// ==== rtl/executeStage.sv ====
////////////////////////////////////////////////////////////
// Execute stage
// Operand forwarding, ALU and destination select
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module executeStage (
  input  mipsPipePkg::idEx_t   idEx,
  input  mipsIsaPkg::word_t    memAluOut,
  input  mipsIsaPkg::word_t    wbResult,
  input  mipsPipePkg::fwdSel_t forwardA,
  input  mipsPipePkg::fwdSel_t forwardB,
  output mipsPipePkg::exMem_t  exMem
);
  import mipsIsaPkg::*;
  import mipsPipePkg::*;

  word_t srcA;
  word_t srcB;
  word_t writeData;
  word_t aluOut;

  // Forwarding mux for one operand
  function automatic word_t pickOperand(
    input fwdSel_t sel,
    input word_t   regVal,
    input word_t   memVal,
    input word_t   wbVal
  );
    word_t val;
    case (sel)
      FWD_MEM: val = memVal;
      FWD_WB:  val = wbVal;
      default: val = regVal;
    endcase
    return val;
  endfunction

  always_comb begin
    srcA      = pickOperand(forwardA, idEx.rd1, memAluOut, wbResult);
    writeData = pickOperand(forwardB, idEx.rd2, memAluOut, wbResult);
    // Immediate for addi, lw, sw
    srcB      = idEx.ctrl.aluSrc ? idEx.signImm : writeData;
  end

  // ALU
  always_comb begin
    case (idEx.ctrl.aluOp)
      ALU_AND: aluOut = srcA & srcB;
      ALU_OR:  aluOut = srcA | srcB;
      ALU_ADD: aluOut = srcA + srcB;
      ALU_SUB: aluOut = srcA - srcB;
      ALU_SLT: aluOut = word_t'($signed(srcA) < $signed(srcB));
      default: aluOut = srcA + srcB;
    endcase
  end

  // Memory payload
  always_comb begin
    exMem.regWrite  = idEx.ctrl.regWrite;
    exMem.memToReg  = idEx.ctrl.memToReg;
    exMem.memWrite  = idEx.ctrl.memWrite;
    exMem.aluOut    = aluOut;
    exMem.writeData = writeData;
    exMem.writeReg  = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
  end

endmodule

// ==== rtl/decodeStage.sv ====
////////////////////////////////////////////////////////////
// Decode stage
// Register file, field extraction, sign extension
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mips_defines.svh"

module decodeStage (
  input  logic                clk,
  input  logic                ci_rst,
  input  mipsIsaPkg::instr_t  instr,
  input  mipsPipePkg::ctrl_t  ctrl,
  input  mipsPipePkg::memWb_t wb,
  output mipsPipePkg::idEx_t  idEx
);
  import mipsIsaPkg::*;
  import mipsPipePkg::*;

  localparam int REG_N = 2 ** `MIPS_REG_AW;

  word_t regFile [REG_N];
  logic  wbWrites;

  // r0 is hardwired zero
  assign wbWrites = wb.regWrite && (wb.writeReg != '0);

  // Written in Writeback
  always_ff @(posedge clk or posedge ci_rst) begin
    if (ci_rst) begin
      for (int i = 0; i < REG_N; i++) begin
        regFile[i] <= '0;
      end
    end else if (wbWrites) begin
      regFile[wb.writeReg] <= wb.result;
    end
  end

  // Reads see the same-cycle Writeback value
  always_comb begin
    idEx.ctrl    = ctrl;
    idEx.rs      = instr.rs;
    idEx.rt      = instr.rt;
    idEx.rd      = instr.rd;
    idEx.rd1     = (wbWrites && wb.writeReg == instr.rs) ? wb.result : regFile[instr.rs];
    idEx.rd2     = (wbWrites && wb.writeReg == instr.rt) ? wb.result : regFile[instr.rt];
    // Sign extend low half
    idEx.signImm = {{16{instr[15]}}, instr[15:0]};
  end

endmodule

// ==== rtl/hazardUnit.sv ====
////////////////////////////////////////////////////////////
// Hazard unit
// Execute forwarding selects and load-use stall
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hazardUnit (
  input  mipsIsaPkg::regIdx_t  idRs,
  input  mipsIsaPkg::regIdx_t  idRt,
  input  mipsIsaPkg::regIdx_t  exRs,
  input  mipsIsaPkg::regIdx_t  exRt,
  input  mipsIsaPkg::regIdx_t  memWriteReg,
  input  mipsIsaPkg::regIdx_t  wbWriteReg,
  input  logic                 exMemToReg,
  input  logic                 memRegWrite,
  input  logic                 wbRegWrite,
  output mipsPipePkg::fwdSel_t forwardA,
  output mipsPipePkg::fwdSel_t forwardB,
  output logic                 stall
);
  import mipsIsaPkg::*;
  import mipsPipePkg::*;

  // Newest producer wins, r0 never forwarded
  function automatic fwdSel_t pickSource(
    input regIdx_t src
  );
    fwdSel_t sel;
    if (src != '0 && memRegWrite && src == memWriteReg) begin
      sel = FWD_MEM;
    end else if (src != '0 && wbRegWrite && src == wbWriteReg) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_REG;
    end
    return sel;
  endfunction

  always_comb begin
    forwardA = pickSource(exRs);
    forwardB = pickSource(exRt);
  end

  // Load in Execute feeding the Decode instruction
  assign stall = exMemToReg && ((exRt == idRs) || (exRt == idRt));

endmodule

// ==== rtl/controlUnit.sv ====
////////////////////////////////////////////////////////////
// Control unit
// Main decoder and ALU decoder
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module controlUnit (
  input  mipsIsaPkg::instr_t instr,
  output mipsPipePkg::ctrl_t ctrl
);
  import mipsIsaPkg::*;
  import mipsPipePkg::*;

  logic   isRtype;
  logic   functOk;
  aluOp_t rtypeOp;
  ctrl_t  mainCtrl;

  // Main decoder
  // Unknown opcode stays all zero
  always_comb begin
    mainCtrl = '0;
    isRtype  = 1'b0;
    case (instr.opcode)
      OP_RTYPE: begin
        isRtype           = 1'b1;
        mainCtrl.regWrite = 1'b1;
        mainCtrl.regDst   = 1'b1;
      end
      OP_LW: begin
        mainCtrl.regWrite = 1'b1;
        mainCtrl.memToReg = 1'b1;
        mainCtrl.aluSrc   = 1'b1;
        mainCtrl.aluOp    = ALU_ADD;
      end
      OP_SW: begin
        mainCtrl.memWrite = 1'b1;
        mainCtrl.aluSrc   = 1'b1;
        mainCtrl.aluOp    = ALU_ADD;
      end
      OP_ADDI: begin
        mainCtrl.regWrite = 1'b1;
        mainCtrl.aluSrc   = 1'b1;
        mainCtrl.aluOp    = ALU_ADD;
      end
      default: mainCtrl = '0;
    endcase
  end

  // ALU decoder for R-type funct
  always_comb begin
    functOk = 1'b1;
    case (instr.funct)
      FN_ADD: rtypeOp = ALU_ADD;
      FN_SUB: rtypeOp = ALU_SUB;
      FN_AND: rtypeOp = ALU_AND;
      FN_OR:  rtypeOp = ALU_OR;
      FN_SLT: rtypeOp = ALU_SLT;
      default: begin
        functOk = 1'b0;
        rtypeOp = ALU_ADD;
      end
    endcase
  end

  // All-zero word lands here as R-type with funct 0
  always_comb begin
    ctrl = mainCtrl;
    if (isRtype) begin
      ctrl.aluOp = rtypeOp;
      if (!functOk) begin
        ctrl = '0;
      end
    end
  end

endmodule

// ==== rtl/pipeReg.sv ====
////////////////////////////////////////////////////////////
// Pipeline stage register with enable and clear
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pipeReg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     ci_rst,
  input  logic     en,
  input  logic     clr,
  input  payload_t d,
  output payload_t q
);

  // Clear inserts a bubble, only while enabled
  always_ff @(posedge clk or posedge ci_rst) begin
    if (ci_rst) begin
      q <= '0;
    end else if (en) begin
      if (clr) begin
        q <= '0;
      end else begin
        q <= d;
      end
    end
  end

endmodule

// ==== rtl/syncRam.sv ====
////////////////////////////////////////////////////////////
// Single-port synchronous RAM with read enable
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mips_defines.svh"

module syncRam #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                    clk,
  input  logic                    en,
  input  logic                    we,
  input  logic [`MIPS_MEM_AW-1:0] addr,
  input  payload_t                wdata,
  output payload_t                rdata
);

  payload_t mem [2 ** `MIPS_MEM_AW];

  // Read-first; output holds while en is low
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

// ==== rtl/mipsPipePkg.sv ====
////////////////////////////////////////////////////////////
// Pipeline bundles
// Control word, stage payloads and observation ports
////////////////////////////////////////////////////////////
`include "mips_defines.svh"

package mipsPipePkg;

  // Decoded control for one instruction
  typedef struct packed {
    logic               regWrite;
    logic               memToReg;
    logic               memWrite;
    logic               aluSrc;
    logic               regDst;
    mipsIsaPkg::aluOp_t aluOp;
  } ctrl_t;

  // Fetch to Decode
  typedef struct packed {
    mipsIsaPkg::instr_t instr;
    mipsIsaPkg::word_t  pcPlus4;
  } ifId_t;

  // Decode to Execute
  typedef struct packed {
    ctrl_t               ctrl;
    mipsIsaPkg::word_t   rd1;
    mipsIsaPkg::word_t   rd2;
    mipsIsaPkg::regIdx_t rs;
    mipsIsaPkg::regIdx_t rt;
    mipsIsaPkg::regIdx_t rd;
    mipsIsaPkg::word_t   signImm;
  } idEx_t;

  // Execute to Memory
  typedef struct packed {
    logic                regWrite;
    logic                memToReg;
    logic                memWrite;
    mipsIsaPkg::word_t   aluOut;
    mipsIsaPkg::word_t   writeData;
    mipsIsaPkg::regIdx_t writeReg;
  } exMem_t;

  // Memory to Writeback
  typedef struct packed {
    logic                regWrite;
    mipsIsaPkg::word_t   result;
    mipsIsaPkg::regIdx_t writeReg;
  } memWb_t;

  // Operand source in Execute
  typedef enum logic [1:0] {
    FWD_REG = 2'b00,
    FWD_WB  = 2'b01,
    FWD_MEM = 2'b10
  } fwdSel_t;

  // Register write-back observation
  typedef struct packed {
    logic                valid;
    mipsIsaPkg::regIdx_t addr;
    mipsIsaPkg::word_t   data;
  } regWrite_t;

  // Data memory write observation (word address)
  typedef struct packed {
    logic                    valid;
    logic [`MIPS_MEM_AW-1:0] addr;
    mipsIsaPkg::word_t       data;
  } memWrite_t;

endpackage

// ==== rtl/mipsIsaPkg.sv ====
////////////////////////////////////////////////////////////
// MIPS instruction set
// Opcode and funct codes, ALU operations, instruction layout
////////////////////////////////////////////////////////////
`include "mips_defines.svh"

package mipsIsaPkg;

  typedef logic [`MIPS_REG_AW-1:0] regIdx_t;
  typedef logic [`MIPS_DATA_W-1:0] word_t;

  // Primary opcodes kept by this core
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B
  } opcode_t;

  // R-type funct codes
  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2A
  } funct_t;

  // ALU control encoding
  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } aluOp_t;

  // Immediate is the low 16 bits
  typedef struct packed {
    opcode_t    opcode;
    regIdx_t    rs;
    regIdx_t    rt;
    regIdx_t    rd;
    logic [4:0] shamt;
    funct_t     funct;
  } instr_t;

endpackage

// ==== rtl/mips_defines.svh ====
////////////////////////////////////////////////////////////
// MIPS core widths
// Shared by the packages and the RTL
////////////////////////////////////////////////////////////
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Data and instruction word
`define MIPS_DATA_W 32

// Register number
`define MIPS_REG_AW 5

// Word address of each on-chip memory (256 words)
`define MIPS_MEM_AW 8

`endif
